//--- design/vend_pkg.sv
`default_nettype none

package vend_pkg;

    typedef enum logic [2:0] {
        IDLE,
        TYPE,
        AMOUNT,
        PAYMENT,
        RELEASE,
        CHANGE
    } vend_state_t;

    typedef logic [6:0] money_t;    // whole units
    typedef logic [1:0] qty_t;

    typedef enum logic [1:0] {
        NONE,
        C,
        S,
        A
    } product_t;

    localparam int NUM_BTN = 5;

    // bit positions in the press vector
    typedef enum logic [2:0] {
        BTN_L,
        BTN_C,
        BTN_R,
        BTN_U,
        BTN_D
    } btn_idx_t;

    typedef logic [NUM_BTN-1:0] btn_vec_t;

    localparam money_t PRICE_C = 7'd5;
    localparam money_t PRICE_S = 7'd10;
    localparam money_t PRICE_A = 7'd15;

    localparam money_t COIN_L = 7'd1;
    localparam money_t COIN_C = 7'd5;
    localparam money_t COIN_R = 7'd10;

    localparam qty_t   MAX_QTY        = 2'd3;
    localparam money_t MONEY_MAX      = 7'd99;  // paid amount saturates here
    localparam int     RELEASE_BLINKS = 5;

endpackage

`default_nettype wire

//--- design/disp_pkg.sv
`default_nettype none

package disp_pkg;

    localparam int NUM_DIGITS = 4;

    // 0..9 are plain digits
    typedef logic [3:0] digit_code_t;

    // index 3 is the leftmost digit
    typedef digit_code_t [NUM_DIGITS-1:0] disp_digits_t;

    typedef logic [6:0] seg_t;              // active low, g down to a
    typedef logic [NUM_DIGITS-1:0] an_t;    // active low digit enables

    localparam digit_code_t GLYPH_DASH  = 4'd10;
    localparam digit_code_t GLYPH_C     = 4'd11;
    localparam digit_code_t GLYPH_S     = 4'd12;
    localparam digit_code_t GLYPH_A     = 4'd13;
    localparam digit_code_t GLYPH_BLANK = 4'd14;

    localparam seg_t SEG_OFF = 7'b111_1111;

endpackage

`default_nettype wire

//--- design/press_if.sv
`timescale 1ns/1ps
`default_nettype none

// button press pulses, conditioners to controller
interface press_if
    import vend_pkg::*;
();

    btn_vec_t press;    // one clk wide per press

    modport drv (
        output press
    );

    modport ctrl (
        input press
    );

endinterface

`default_nettype wire

//--- design/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int SAMPLE_DIV = 100_000,
    parameter int SCAN_DIV   = 50_000,
    parameter int BLINK_DIV  = 100_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic sample_tick,
    output logic scan_tick,
    output logic blink_tick
);

    localparam int NUM_TICKS = 3;

    logic [NUM_TICKS-1:0] ticks;

    for (genvar i = 0; i < NUM_TICKS; i++) begin : g_div
        localparam int DIV   = (i == 0) ? SAMPLE_DIV : (i == 1) ? SCAN_DIV : BLINK_DIV;
        localparam int CNT_W = $clog2(DIV + 1);

        logic [CNT_W-1:0] cnt;
        logic             tick_q;

        // tick is registered, so it lands DIV clocks after reset
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt    <= '0;
                tick_q <= 1'b0;
            end else if (cnt == CNT_W'(DIV - 1)) begin
                cnt    <= '0;
                tick_q <= 1'b1;
            end else begin
                cnt    <= cnt + 1'b1;
                tick_q <= 1'b0;
            end
        end

        assign ticks[i] = tick_q;
    end

    assign sample_tick = ticks[0];
    assign scan_tick   = ticks[1];
    assign blink_tick  = ticks[2];

endmodule

`default_nettype wire

//--- design/button_cond.sv
`timescale 1ns/1ps
`default_nettype none

module button_cond #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic sample_tick,
    input  logic btn,
    output logic press
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    level;
    logic                    level_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
        end else if (sample_tick) begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn};
        end
    end

    assign level = &samples;    // stable high over the whole window

    // rising edge of the debounced level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_q <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_q <= level;
            press   <= level & ~level_q;
        end
    end

endmodule

`default_nettype wire

//--- design/vend_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vend_ctrl
    import vend_pkg::*, disp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         blink_tick,
    press_if.ctrl        presses,
    output disp_digits_t digits,
    output logic [15:0]  led
);

    localparam int REL_W = $clog2(RELEASE_BLINKS + 1);

    vend_state_t      state, state_n;
    product_t         product, product_n;
    qty_t             qty, qty_n;
    money_t           paid, paid_n;
    money_t           total, total_n;
    money_t           balance, balance_n;
    logic [REL_W-1:0] rel_cnt, rel_cnt_n;
    logic [15:0]      led_n;
    btn_vec_t         press;
    logic             lcr_hit;
    money_t           coin;

    function automatic money_t unit_price(product_t p);
        case (p)
            C:       return PRICE_C;
            S:       return PRICE_S;
            A:       return PRICE_A;
            default: return '0;
        endcase
    endfunction

    function automatic digit_code_t letter(product_t p);
        case (p)
            C:       return GLYPH_C;
            S:       return GLYPH_S;
            A:       return GLYPH_A;
            default: return GLYPH_BLANK;
        endcase
    endfunction

    // L, C, R pick the product, priority in that order
    function automatic product_t pick_product(btn_vec_t p);
        if (p[BTN_L]) return C;
        else if (p[BTN_C]) return S;
        else return A;
    endfunction

    function automatic money_t coin_value(btn_vec_t p);
        if (p[BTN_L]) return COIN_L;
        else if (p[BTN_C]) return COIN_C;
        else return COIN_R;
    endfunction

    function automatic digit_code_t tens(money_t m);
        return digit_code_t'(m / money_t'(10));
    endfunction

    function automatic digit_code_t units(money_t m);
        return digit_code_t'(m % money_t'(10));
    endfunction

    assign press   = presses.press;
    assign lcr_hit = press[BTN_L] | press[BTN_C] | press[BTN_R];
    assign coin    = coin_value(press);

    always_comb begin
        state_n   = state;
        product_n = product;
        qty_n     = qty;
        paid_n    = paid;
        total_n   = total;
        balance_n = balance;
        rel_cnt_n = rel_cnt;
        case (state)
            IDLE: begin
                if (lcr_hit) begin
                    state_n   = TYPE;
                    product_n = pick_product(press);
                end
            end
            TYPE: begin
                if (lcr_hit) begin
                    product_n = pick_product(press);
                end else if (press[BTN_U]) begin
                    state_n = AMOUNT;
                    qty_n   = qty_t'(1);
                end else if (press[BTN_D]) begin
                    state_n   = IDLE;
                    product_n = NONE;
                end
            end
            AMOUNT: begin
                if (press[BTN_L]) begin
                    if (qty > qty_t'(1)) qty_n = qty - qty_t'(1);
                end else if (press[BTN_R]) begin
                    if (qty < MAX_QTY) qty_n = qty + qty_t'(1);
                end else if (press[BTN_U]) begin
                    state_n = PAYMENT;
                    total_n = money_t'(unit_price(product) * qty);
                    paid_n  = '0;
                end else if (press[BTN_D]) begin
                    state_n   = IDLE;
                    product_n = NONE;
                end
            end
            PAYMENT: begin
                if (paid >= total) begin
                    state_n   = RELEASE;
                    balance_n = paid - total;
                    rel_cnt_n = '0;
                end else if (lcr_hit) begin
                    if (coin <= MONEY_MAX - paid) paid_n = paid + coin;   // else dropped
                end else if (press[BTN_D]) begin
                    state_n   = CHANGE;
                    balance_n = paid;   // full refund
                end
            end
            RELEASE: begin
                if (blink_tick) begin
                    if (rel_cnt == REL_W'(RELEASE_BLINKS - 1)) begin
                        state_n = CHANGE;
                    end else begin
                        rel_cnt_n = rel_cnt + 1'b1;
                    end
                end
            end
            CHANGE: begin
                if (blink_tick) begin
                    if (balance == '0) begin
                        state_n   = IDLE;
                        product_n = NONE;
                    end else if (balance >= COIN_C) begin
                        balance_n = balance - COIN_C;
                    end else begin
                        balance_n = balance - COIN_L;
                    end
                end
            end
            default: state_n = IDLE;
        endcase
    end

    // blink only while staying in idle or release, dark otherwise
    always_comb begin
        led_n = '0;
        if (state_n == IDLE || state_n == RELEASE) begin
            led_n = (blink_tick && state_n == state) ? ~led : led;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            product <= NONE;
            qty     <= '0;
            paid    <= '0;
            total   <= '0;
            balance <= '0;
            rel_cnt <= '0;
            led     <= '0;
        end else begin
            state   <= state_n;
            product <= product_n;
            qty     <= qty_n;
            paid    <= paid_n;
            total   <= total_n;
            balance <= balance_n;
            rel_cnt <= rel_cnt_n;
            led     <= led_n;
        end
    end

    always_comb begin
        digits = {NUM_DIGITS{GLYPH_BLANK}};
        case (state)
            IDLE: begin
                if (led[0]) digits = {NUM_DIGITS{GLYPH_DASH}};  // in step with the leds
            end
            TYPE: begin
                digits[3] = letter(product);
                digits[1] = tens(unit_price(product));
                digits[0] = units(unit_price(product));
            end
            AMOUNT, RELEASE: begin
                digits[3] = letter(product);
                digits[0] = digit_code_t'(qty);
            end
            PAYMENT: begin
                digits[3] = tens(paid);
                digits[2] = units(paid);
                digits[1] = tens(total);
                digits[0] = units(total);
            end
            CHANGE: begin
                digits[1] = tens(balance);
                digits[0] = units(balance);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/seg_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg_scan
    import disp_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         scan_tick,
    input  disp_digits_t digits,
    output an_t          an,
    output seg_t         seg
);

    localparam int SEL_W = $clog2(NUM_DIGITS);

    logic [SEL_W-1:0] sel;     // digit currently lit
    digit_code_t      code;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (scan_tick) begin
            if (sel == SEL_W'(NUM_DIGITS - 1)) begin
                sel <= '0;
            end else begin
                sel <= sel + 1'b1;
            end
        end
    end

    // one-cold enable follows sel
    always_comb begin
        an      = '1;
        an[sel] = 1'b0;
    end

    assign code = digits[sel];

    always_comb begin
        case (code)
            4'd0:        seg = 7'b100_0000;
            4'd1:        seg = 7'b111_1001;
            4'd2:        seg = 7'b010_0100;
            4'd3:        seg = 7'b011_0000;
            4'd4:        seg = 7'b001_1001;
            4'd5:        seg = 7'b001_0010;
            4'd6:        seg = 7'b000_0010;
            4'd7:        seg = 7'b111_1000;
            4'd8:        seg = 7'b000_0000;
            4'd9:        seg = 7'b001_0000;
            GLYPH_DASH:  seg = 7'b011_1111;   // middle bar only
            GLYPH_C:     seg = 7'b100_0110;
            GLYPH_S:     seg = 7'b001_0010;   // same shape as 5
            GLYPH_A:     seg = 7'b000_1000;
            GLYPH_BLANK: seg = SEG_OFF;
            default:     seg = SEG_OFF;
        endcase
    end

endmodule

`default_nettype wire

//--- design/vend_top.sv
`timescale 1ns/1ps
`default_nettype none

module vend_top
    import vend_pkg::*, disp_pkg::*;
#(
    parameter int SAMPLE_DIV   = 100_000,
    parameter int SCAN_DIV     = 50_000,
    parameter int BLINK_DIV    = 100_000_000,
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_l,
    input  logic        btn_c,
    input  logic        btn_r,
    input  logic        btn_u,
    input  logic        btn_d,
    output logic [15:0] led,
    output an_t         digit,
    output seg_t        display
);

    logic         sample_tick;
    logic         scan_tick;
    logic         blink_tick;
    btn_vec_t     btn_raw;
    disp_digits_t digits;

    press_if presses ();

    assign btn_raw[BTN_L] = btn_l;
    assign btn_raw[BTN_C] = btn_c;
    assign btn_raw[BTN_R] = btn_r;
    assign btn_raw[BTN_U] = btn_u;
    assign btn_raw[BTN_D] = btn_d;

    tick_gen #(
        .SAMPLE_DIV (SAMPLE_DIV),
        .SCAN_DIV   (SCAN_DIV),
        .BLINK_DIV  (BLINK_DIV)
    ) u_tick_gen (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .scan_tick   (scan_tick),
        .blink_tick  (blink_tick)
    );

    // one conditioner per button, each owns its press bit
    for (genvar i = 0; i < NUM_BTN; i++) begin : g_btn
        button_cond #(
            .DEBOUNCE_LEN (DEBOUNCE_LEN)
        ) u_button_cond (
            .clk         (clk),
            .rst         (rst),
            .sample_tick (sample_tick),
            .btn         (btn_raw[i]),
            .press       (presses.press[i])
        );
    end

    vend_ctrl u_vend_ctrl (
        .clk        (clk),
        .rst        (rst),
        .blink_tick (blink_tick),
        .presses    (presses.ctrl),
        .digits     (digits),
        .led        (led)
    );

    seg_scan u_seg_scan (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .digits    (digits),
        .an        (digit),
        .seg       (display)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/tb_vend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vend;

    localparam int SAMPLE_DIV   = 2;
    localparam int SCAN_DIV     = 4;
    localparam int BLINK_DIV    = 64;
    localparam int DEBOUNCE_LEN = 3;
    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 8;
    localparam int HOLD_CYCLES  = 20;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES + 2;
    localparam int PAY_ROUNDS   = 3;

    // idle, selection + quantity + cancel presses, payment rounds
    localparam int TEST_CYCLES = RST_CYCLES + 3 * BLINK_DIV + 19 * PRESS_CYCLES
        + 8 * BLINK_DIV + PAY_ROUNDS * (50 * PRESS_CYCLES + 22 * BLINK_DIV);

    localparam int M_IDLE    = 0;
    localparam int M_TYPE    = 1;
    localparam int M_AMOUNT  = 2;
    localparam int M_PAYMENT = 3;
    localparam int M_RELEASE = 4;
    localparam int M_CHANGE  = 5;

    localparam int B_L = 0;
    localparam int B_C = 1;
    localparam int B_R = 2;
    localparam int B_U = 3;
    localparam int B_D = 4;

    localparam int G_DASH  = 10;
    localparam int G_C     = 11;
    localparam int G_S     = 12;
    localparam int G_A     = 13;
    localparam int G_BLANK = 14;

    logic        clk;
    logic        rst;
    logic        btn_l;
    logic        btn_c;
    logic        btn_r;
    logic        btn_u;
    logic        btn_d;
    logic [15:0] led;
    logic [3:0]  digit;
    logic [6:0]  display;

    logic [6:0]  shadow_seg [4];    // last segments seen per digit
    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    // reference model
    int   m_state;
    int   m_prod;
    int   m_qty;
    int   m_paid;
    int   m_total;
    int   m_bal;
    int   m_rel;
    logic m_led;
    logic m_tick;
    int   blink_cnt;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    vend_top #(
        .SAMPLE_DIV   (SAMPLE_DIV),
        .SCAN_DIV     (SCAN_DIV),
        .BLINK_DIV    (BLINK_DIV),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .btn_l   (btn_l),
        .btn_c   (btn_c),
        .btn_r   (btn_r),
        .btn_u   (btn_u),
        .btn_d   (btn_d),
        .led     (led),
        .digit   (digit),
        .display (display)
    );

    function automatic int price(input int prod);
        case (prod)
            1:       return 5;
            2:       return 10;
            3:       return 15;
            default: return 0;
        endcase
    endfunction

    function automatic int letter_code(input int prod);
        case (prod)
            1:       return G_C;
            2:       return G_S;
            3:       return G_A;
            default: return G_BLANK;
        endcase
    endfunction

    // active low, g down to a
    function automatic logic [6:0] glyph_segments(input int code);
        case (code)
            0:       return 7'b100_0000;
            1:       return 7'b111_1001;
            2:       return 7'b010_0100;
            3:       return 7'b011_0000;
            4:       return 7'b001_1001;
            5:       return 7'b001_0010;
            6:       return 7'b000_0010;
            7:       return 7'b111_1000;
            8:       return 7'b000_0000;
            9:       return 7'b001_0000;
            G_DASH:  return 7'b011_1111;
            G_C:     return 7'b100_0110;
            G_S:     return 7'b001_0010;
            G_A:     return 7'b000_1000;
            default: return 7'b111_1111;
        endcase
    endfunction

    function automatic int expected_code(input int pos);
        case (m_state)
            M_IDLE: return m_led ? G_DASH : G_BLANK;
            M_TYPE: begin
                if (pos == 3) return letter_code(m_prod);
                if (pos == 2) return G_BLANK;
                return (pos == 1) ? price(m_prod) / 10 : price(m_prod) % 10;
            end
            M_AMOUNT, M_RELEASE: begin
                if (pos == 3) return letter_code(m_prod);
                return (pos == 0) ? m_qty : G_BLANK;
            end
            M_PAYMENT: begin
                case (pos)
                    3:       return m_paid / 10;
                    2:       return m_paid % 10;
                    1:       return m_total / 10;
                    default: return m_total % 10;
                endcase
            end
            default: begin
                if (pos >= 2) return G_BLANK;
                return (pos == 1) ? m_bal / 10 : m_bal % 10;
            end
        endcase
    endfunction

    // -1 unless exactly one enable is low
    function automatic int active_digit(input logic [3:0] an);
        int pos;
        int lows;
        int k;
        pos = -1;
        lows = 0;
        for (k = 0; k < 4; k++) begin
            if (an[k] === 1'b0) begin
                pos = k;
                lows++;
            end
        end
        return (lows == 1) ? pos : -1;
    endfunction

    function automatic int rand_index(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
        $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // own blink tick, first one BLINK_DIV clocks after reset
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            blink_cnt <= 0;
            m_tick    <= 1'b0;
        end else if (blink_cnt == BLINK_DIV - 1) begin
            blink_cnt <= 0;
            m_tick    <= 1'b1;
        end else begin
            blink_cnt <= blink_cnt + 1;
            m_tick    <= 1'b0;
        end
    end

    // model steps on the press pulses, priority L C R U D
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_state <= M_IDLE;
            m_prod  <= 0;
            m_qty   <= 0;
            m_paid  <= 0;
            m_total <= 0;
            m_bal   <= 0;
            m_rel   <= 0;
            m_led   <= 1'b0;
        end else begin : step
            logic [4:0] p;
            int         ns;
            int         coin;
            p = UUT.presses.press;
            ns = m_state;
            coin = p[B_L] ? 1 : (p[B_C] ? 5 : 10);
            case (m_state)
                M_IDLE: begin
                    if (p[B_L] | p[B_C] | p[B_R]) begin
                        ns = M_TYPE;
                        m_prod <= p[B_L] ? 1 : (p[B_C] ? 2 : 3);
                    end
                end
                M_TYPE: begin
                    if (p[B_L] | p[B_C] | p[B_R]) begin
                        m_prod <= p[B_L] ? 1 : (p[B_C] ? 2 : 3);
                    end else if (p[B_U]) begin
                        ns = M_AMOUNT;
                        m_qty <= 1;
                    end else if (p[B_D]) begin
                        ns = M_IDLE;
                    end
                end
                M_AMOUNT: begin
                    if (p[B_L]) begin
                        if (m_qty > 1) m_qty <= m_qty - 1;
                    end else if (p[B_R]) begin
                        if (m_qty < 3) m_qty <= m_qty + 1;
                    end else if (p[B_U]) begin
                        ns = M_PAYMENT;
                        m_total <= price(m_prod) * m_qty;
                        m_paid  <= 0;
                    end else if (p[B_D]) begin
                        ns = M_IDLE;
                    end
                end
                M_PAYMENT: begin
                    if (m_paid >= m_total) begin
                        ns = M_RELEASE;
                        m_bal <= m_paid - m_total;
                        m_rel <= 0;
                    end else if (p[B_L] | p[B_C] | p[B_R]) begin
                        if (m_paid + coin <= 99) m_paid <= m_paid + coin;
                    end else if (p[B_D]) begin
                        ns = M_CHANGE;
                        m_bal <= m_paid;
                    end
                end
                M_RELEASE: begin
                    if (m_tick) begin
                        if (m_rel == 4) ns = M_CHANGE;
                        else m_rel <= m_rel + 1;
                    end
                end
                default: begin
                    if (m_tick) begin
                        if (m_bal == 0) ns = M_IDLE;
                        else if (m_bal >= 5) m_bal <= m_bal - 5;
                        else m_bal <= m_bal - 1;
                    end
                end
            endcase
            if (ns != M_IDLE && ns != M_RELEASE) begin
                m_led <= 1'b0;      // dark outside idle and release
            end else if (m_tick && (m_state == M_IDLE || m_state == M_RELEASE)) begin
                m_led <= ~m_led;
            end
            m_state <= ns;
        end
    end

    // outputs settle between edges
    always @(negedge clk) begin : check_outputs
        int         pos;
        logic [6:0] want;
        if ($time > 0) begin    // clk steps from x to 0 at time zero
            pos = active_digit(digit);
            checks += 3;
            assert (pos >= 0) else begin
                $display("FAIL %0t ns digit enable is not one-cold: %b", $time, digit);
                errors++;
            end
            if (pos >= 0) begin
                shadow_seg[pos] = display;
                want = glyph_segments(expected_code(pos));
                assert (display === want) else
                    mismatch($sformatf("display[%0d]", pos), display, want);
            end
            assert (led === {16{m_led}}) else mismatch("led", led, {16{m_led}});
        end
    end

    task automatic set_button(input int idx, input logic v);
        case (idx)
            B_L:     btn_l <= v;
            B_C:     btn_c <= v;
            B_R:     btn_r <= v;
            B_U:     btn_u <= v;
            default: btn_d <= v;
        endcase
    endtask

    task automatic press_button(input int idx);
        int pulses;
        pulses = 0;
        @(posedge clk);
        set_button(idx, 1'b1);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (UUT.presses.press[idx] === 1'b1) pulses++;
        end
        @(posedge clk);
        set_button(idx, 1'b0);
        repeat (HOLD_CYCLES) @(posedge clk);
        checks++;
        assert (pulses == 1) else begin
            $display("button %0d was held but gave %0d press pulses instead of one (%0t ns)",
                     idx, pulses, $time);
            errors++;
        end
    endtask

    task automatic expect_state(input int target);
        checks++;
        assert (m_state == target) else mismatch("state", m_state, target);
    endtask

    task automatic expect_display(input int d3, input int d2, input int d1, input int d0);
        int         want [4];
        int         k;
        logic [6:0] seg;
        want[3] = d3;
        want[2] = d2;
        want[1] = d1;
        want[0] = d0;
        for (k = 0; k < 4; k++) begin
            seg = glyph_segments(want[k]);
            checks++;
            assert (shadow_seg[k] === seg) else
                mismatch($sformatf("shadow digit %0d", k), shadow_seg[k], seg);
        end
    endtask

    task automatic wait_state(input int target, input int max_cycles);
        int n;
        n = 0;
        while (m_state != target && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (m_state == target) else begin
            $display("state %0d not reached within %0d cycles", target, max_cycles);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "with errors", errors - err_mark);
        err_mark = errors;
    endtask

    task automatic pay_round();
        int prod;
        int qty;
        int n;
        prod = rand_index(3) + 1;
        qty  = rand_index(3) + 1;
        press_button(prod - 1);     // L, C, R map to C, S, A
        press_button(B_U);
        repeat (qty - 1) press_button(B_R);
        press_button(B_U);
        expect_state(M_PAYMENT);
        n = 0;
        while (m_state == M_PAYMENT && n < 50) begin
            press_button(rand_index(3));
            n++;
        end
        expect_state(M_RELEASE);
        expect_display(letter_code(prod), G_BLANK, G_BLANK, qty);
        wait_state(M_IDLE, 24 * BLINK_DIV);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed = 32'ha845de88;
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        rst = 1'b1;
        btn_l = 1'b0;
        btn_c = 1'b0;
        btn_r = 1'b0;
        btn_u = 1'b0;
        btn_d = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        repeat (3 * BLINK_DIV) @(posedge clk);  // idle blinking
        end_test("idle");

        press_button(B_L);
        expect_state(M_TYPE);
        expect_display(G_C, G_BLANK, 0, 5);
        press_button(B_C);
        expect_display(G_S, G_BLANK, 1, 0);
        press_button(B_R);
        expect_display(G_A, G_BLANK, 1, 5);
        press_button(B_D);
        expect_state(M_IDLE);
        end_test("select");

        press_button(B_C);
        press_button(B_U);
        expect_display(G_S, G_BLANK, G_BLANK, 1);
        repeat (3) press_button(B_R);
        expect_display(G_S, G_BLANK, G_BLANK, 3);
        repeat (3) press_button(B_L);
        expect_display(G_S, G_BLANK, G_BLANK, 1);
        press_button(B_D);
        expect_state(M_IDLE);
        end_test("quantity");

        repeat (PAY_ROUNDS) pay_round();
        end_test("payment");

        press_button(B_R);
        press_button(B_U);
        press_button(B_U);
        press_button(B_L);
        press_button(B_C);
        expect_display(0, 6, 1, 5);
        press_button(B_D);
        expect_state(M_CHANGE);
        wait_state(M_IDLE, 8 * BLINK_DIV);
        end_test("cancel");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/vend_pkg.sv
design/disp_pkg.sv
design/press_if.sv
design/tick_gen.sv
design/button_cond.sv
design/vend_ctrl.sv
design/seg_scan.sv
design/vend_top.sv
testbench/tb_clock.sv
testbench/tb_vend.sv
